// ==== sim.f ====
hw/pcs_pkg.sv
hw/block_tagger.sv
hw/parallel_converter_1_to_n.sv
hw/frame_checker.sv
hw/pcs_block_gather.sv
tests/pcs_block_gather_assertions.sv
tests/tb_pcs_block_gather.sv

// ==== Bender.yml ====
package:
  name: pcs_block_gather

sources:
  - files:
      - hw/pcs_pkg.sv
      - hw/block_tagger.sv
      - hw/parallel_converter_1_to_n.sv
      - hw/frame_checker.sv
      - hw/pcs_block_gather.sv
  - target: test
    files:
      - tests/pcs_block_gather_assertions.sv
      - tests/tb_pcs_block_gather.sv

// ==== tests/tb_pcs_block_gather.sv ====
`timescale 1ns/10ps

module tb_pcs_block_gather;

    localparam int N_LANES        = 4;
    localparam int N_FRAMES       = 40;
    localparam int N_BLOCKS       = N_FRAMES * N_LANES;
    localparam int TIMEOUT_CYCLES = N_BLOCKS * 3 + 200;
    localparam int NB_BLOCK       = pcs_pkg::NB_BLOCK;
    localparam int NB_FRAME       = NB_BLOCK * N_LANES;

    logic                                clock;
    logic                                reset;
    logic                                enable;
    logic                                valid;
    logic [NB_BLOCK-1:0]                 data;
    logic                                frame_valid;
    logic [NB_FRAME-1:0]                 frame_data;
    logic [N_LANES-1:0]                  error_mask;
    logic [N_LANES-1:0]                  control_mask;
    logic [15:0]                         error_frames;

    logic [31:0]                         lfsr_state;
    pcs_pkg::coded_block_t               accepted_q [$];  // blocks the DUT must have taken
    logic [15:0]                         expected_errors = '0;
    int                                  legal_index = 0;
    int                                  error_count = 0;
    int                                  frames_seen = 0;
    int                                  cycle_count = 0;

    pcs_block_gather #(.N_LANES(N_LANES)) DUT
    (
        .i_clock        (clock),
        .i_reset        (reset),
        .i_enable       (enable),
        .i_valid        (valid),
        .i_data         (data),
        .o_frame_valid  (frame_valid),
        .o_frame_data   (frame_data),
        .o_error_mask   (error_mask),
        .o_control_mask (control_mask),
        .o_error_frames (error_frames)
    );

    initial
    begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic draw_bits(input int n, output logic [63:0] value);
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[62:0], lfsr_state[0]};
        end
    endtask

    function automatic logic type_is_legal(input logic [7:0] block_type);
        case (block_type)
            8'h1E, 8'h2D, 8'h33, 8'h4B, 8'h55, 8'h66, 8'h78, 8'h87,
            8'h99, 8'hAA, 8'hB4, 8'hCC, 8'hD2, 8'hE1, 8'hFF: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic block_has_error(input pcs_pkg::coded_block_t blk);
        if (blk.data.sync == 2'b00 || blk.data.sync == 2'b11)
        begin
            return 1'b1;
        end
        return (blk.ctrl.sync == 2'b10) && !type_is_legal(blk.ctrl.block_type);
    endfunction

    task automatic make_block(output pcs_pkg::coded_block_t blk);
        logic [63:0] kind;
        logic [63:0] bits;
        draw_bits(3, kind);
        draw_bits(64, bits);
        blk.data.payload = bits;
        blk.data.sync    = pcs_pkg::SYNC_DATA;
        case (kind[2:0])
            3'd3, 3'd4:
            begin
                blk.ctrl.sync       = pcs_pkg::SYNC_CTRL;  // walk the legal list in order
                blk.ctrl.block_type = pcs_pkg::LEGAL_BLOCK_TYPES[legal_index];
                legal_index         = (legal_index + 1) % pcs_pkg::N_BLOCK_TYPES;
            end
            3'd5:
            begin
                blk.ctrl.sync = pcs_pkg::SYNC_CTRL;
                if (type_is_legal(blk.ctrl.block_type))
                begin
                    blk.ctrl.block_type[0] = ~blk.ctrl.block_type[0];  // no legal type sits one bit away
                end
            end
            3'd6: blk.data.sync = {2{bits[0]}};  // header 00 or 11
            default: blk.data.sync = pcs_pkg::SYNC_DATA;
        endcase
    endtask

    task automatic drive_cycle(input logic en, input logic vld, input pcs_pkg::coded_block_t blk);
        @(posedge clock);
        enable <= en;
        valid  <= vld;
        data   <= blk;
    endtask

    task automatic compare_value(input string name, input logic [NB_FRAME-1:0] expected,
                                 input logic [NB_FRAME-1:0] actual);
        if (actual !== expected)
        begin
            $display("mismatch at %0t: %s expected %0h got %0h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_frame();
        pcs_pkg::coded_block_t blk;
        logic [NB_FRAME-1:0]   exp_data;
        logic [N_LANES-1:0]    exp_error;
        logic [N_LANES-1:0]    exp_control;
        frames_seen++;
        if (accepted_q.size() < N_LANES)
        begin
            $display("frame at %0t arrived with only %0d accepted blocks behind it",
                     $time, accepted_q.size());
            error_count++;
            return;
        end
        exp_data = '0;
        for (int lane = N_LANES - 1; lane >= 0; lane--)  // oldest block goes on top
        begin
            blk = accepted_q.pop_front();
            exp_data[NB_BLOCK*lane +: NB_BLOCK] = blk;
            exp_error[lane]   = block_has_error(blk);
            exp_control[lane] = (blk.ctrl.sync == 2'b10);
        end
        if (|exp_error && expected_errors != 16'hFFFF)
        begin
            expected_errors++;
        end
        compare_value("o_frame_data", exp_data, frame_data);
        compare_value("o_error_mask", NB_FRAME'(exp_error), NB_FRAME'(error_mask));
        compare_value("o_control_mask", NB_FRAME'(exp_control), NB_FRAME'(control_mask));
        compare_value("o_error_frames", NB_FRAME'(expected_errors), NB_FRAME'(error_frames));
    endtask

    // outputs change on the rising edge and are read half a period later
    always @(negedge clock)
    begin
        if (!reset && frame_valid)
        begin
            check_frame();
        end
    end

    always @(posedge clock)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles with %0d of %0d frames received",
                     cycle_count, frames_seen, N_FRAMES);
            $display("Finished with errors");
            $finish;
        end
    end

    initial
    begin
        pcs_pkg::coded_block_t blk;
        logic [63:0]           r;
        int                    assertion_errors;
        lfsr_state = 32'd85876;
        reset  = 1'b1;
        enable = 1'b0;
        valid  = 1'b0;
        data   = '0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        for (int b = 0; b < N_BLOCKS; b++)
        begin
            draw_bits(2, r);
            if (r[1:0] == 2'd0)
            begin
                draw_bits(2, r);
                repeat (r[1:0] + 1) drive_cycle(1'b1, 1'b0, '0);  // idle gap
            end
            draw_bits(3, r);
            if (r[2:0] == 3'd0)
            begin
                draw_bits(1, r);
                repeat (r[0] + 1)
                begin
                    make_block(blk);
                    drive_cycle(1'b0, 1'b1, blk);  // offered while disabled, must be dropped
                end
            end
            make_block(blk);
            drive_cycle(1'b1, 1'b1, blk);
            accepted_q.push_back(blk);
        end
        drive_cycle(1'b1, 1'b0, '0);
        while (frames_seen < N_FRAMES)
        begin
            @(posedge clock);
        end
        repeat (10) @(posedge clock);  // room for any frame that should not come
        if (frames_seen != N_FRAMES)
        begin
            $display("%0d frames arrived where %0d were expected", frames_seen, N_FRAMES);
            error_count++;
        end
        if (accepted_q.size() != 0)
        begin
            $display("%0d accepted blocks never appeared in a frame", accepted_q.size());
            error_count++;
        end
        assertion_errors = DUT.u_assertions.failures;
        $display("errors: %0d in frame checks, %0d in assertions", error_count, assertion_errors);
        if (error_count == 0 && assertion_errors == 0)
        begin
            $display("Finished with no errors");
        end
        else
        begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== tests/pcs_block_gather_assertions.sv ====
`timescale 1ns/10ps

module pcs_block_gather_assertions
#(
    parameter int N_LANES = 20
)
(
    input  logic                                     i_clock,
    input  logic                                     i_reset,
    input  logic                                     i_enable,
    input  logic                                     i_valid,
    input  logic                                     i_frame_valid,
    input  logic [pcs_pkg::NB_BLOCK*N_LANES-1:0]     i_frame_data,
    input  logic [N_LANES-1:0]                       i_error_mask,
    input  logic [N_LANES-1:0]                       i_control_mask,
    input  logic [15:0]                              i_error_frames
);

    localparam int NB_COUNT = (N_LANES > 1) ? $clog2(N_LANES) : 1;

    int                                              failures = 0;  // read by the testbench top
    logic [NB_COUNT-1:0]                             accept_count;
    logic                                            accept;
    logic                                            frame_done;
    logic                                            counts_error;

    assign accept       = i_enable && i_valid;
    assign frame_done   = accept && (accept_count == NB_COUNT'(N_LANES - 1));
    assign counts_error = i_frame_valid && (|i_error_mask);

    // shadow count of accepted blocks, independent of the DUT's own lane index
    always_ff @(posedge i_clock)
    begin
        if (i_reset || frame_done)
        begin
            accept_count <= '0;
        end
        else if (accept)
        begin
            accept_count <= accept_count + 1'b1;
        end
    end

    reset_clears_outputs : assert property (@(posedge i_clock)
        i_reset |=> (!i_frame_valid && i_frame_data == '0 && i_error_mask == '0 &&
                     i_control_mask == '0 && i_error_frames == '0))
    else
    begin
        $error("outputs are not cleared in the cycle after reset");
        failures = failures + 1;
    end

    frame_follows_last_block : assert property (@(posedge i_clock) disable iff (i_reset)
        frame_done |-> ##3 i_frame_valid)
    else
    begin
        $error("no frame strobe three cycles after the last block of a frame");
        failures = failures + 1;
    end

    no_stray_frame : assert property (@(posedge i_clock) disable iff (i_reset)
        i_frame_valid |-> $past(frame_done, 3))
    else
    begin
        $error("frame strobe without a completed frame three cycles before");
        failures = failures + 1;
    end

    // saturation at all ones is the only case where an errored frame leaves the count alone
    error_count_steps : assert property (@(posedge i_clock) disable iff (i_reset)
        (counts_error && $past(i_error_frames) != 16'hFFFF) |->
            i_error_frames == $past(i_error_frames) + 16'd1)
    else
    begin
        $error("errored frame did not raise the error frame count by one");
        failures = failures + 1;
    end

    error_count_holds : assert property (@(posedge i_clock) disable iff (i_reset)
        !counts_error |-> $stable(i_error_frames))
    else
    begin
        $error("error frame count changed without an errored frame");
        failures = failures + 1;
    end

endmodule

bind pcs_block_gather pcs_block_gather_assertions
#(
    .N_LANES (N_LANES)
)
u_assertions
(
    .i_clock        (i_clock),
    .i_reset        (i_reset),
    .i_enable       (i_enable),
    .i_valid        (i_valid),
    .i_frame_valid  (o_frame_valid),
    .i_frame_data   (o_frame_data),
    .i_error_mask   (o_error_mask),
    .i_control_mask (o_control_mask),
    .i_error_frames (o_error_frames)
);

// ==== hw/pcs_block_gather.sv ====
`timescale 1ns/10ps

module pcs_block_gather
#(
    parameter int N_LANES = 20
)
(
    input  logic                                     i_clock,
    input  logic                                     i_reset,
    input  logic                                     i_enable,
    input  logic                                     i_valid,
    input  logic [pcs_pkg::NB_BLOCK-1:0]             i_data,

    output logic                                     o_frame_valid,
    output logic [pcs_pkg::NB_BLOCK*N_LANES-1:0]     o_frame_data,
    output logic [N_LANES-1:0]                       o_error_mask,
    output logic [N_LANES-1:0]                       o_control_mask,
    output logic [15:0]                              o_error_frames
);

    localparam int NB_BUS = pcs_pkg::NB_TAGGED * N_LANES;

    logic                                            tag_valid;
    logic [pcs_pkg::NB_TAGGED-1:0]                   tag_data;
    logic                                            bus_valid;
    logic [NB_BUS-1:0]                               bus_data;

    // stage 1 applies the enable and marks bad blocks
    block_tagger u_block_tagger
    (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_enable (i_enable),
        .i_valid  (i_valid),
        .i_data   (i_data),
        .o_valid  (tag_valid),
        .o_data   (tag_data)
    );

    // stage 2 gathers N_LANES tagged blocks into one bus word
    parallel_converter_1_to_n
    #(
        .N_LANES (N_LANES)
    )
    u_parallel_converter
    (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_valid (tag_valid),
        .i_data  (tag_data),
        .o_valid (bus_valid),
        .o_data  (bus_data)
    );

    // stage 3 strips tags and reports per-lane status
    frame_checker
    #(
        .N_LANES (N_LANES)
    )
    u_frame_checker
    (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_valid        (bus_valid),
        .i_data         (bus_data),
        .o_valid        (o_frame_valid),
        .o_data         (o_frame_data),
        .o_error_mask   (o_error_mask),
        .o_control_mask (o_control_mask),
        .o_error_frames (o_error_frames)
    );

endmodule

// ==== hw/frame_checker.sv ====
`timescale 1ns/10ps

module frame_checker
#(
    parameter int N_LANES = 20
)
(
    input  logic                                     i_clock,
    input  logic                                     i_reset,
    input  logic                                     i_valid,
    input  logic [pcs_pkg::NB_TAGGED*N_LANES-1:0]    i_data,

    output logic                                     o_valid,
    output logic [pcs_pkg::NB_BLOCK*N_LANES-1:0]     o_data,
    output logic [N_LANES-1:0]                       o_error_mask,
    output logic [N_LANES-1:0]                       o_control_mask,
    output logic [15:0]                              o_error_frames
);

    localparam int NB_FRAME   = pcs_pkg::NB_BLOCK * N_LANES;
    localparam int NB_COUNTER = 16;

    logic [NB_FRAME-1:0]                             stripped_data;
    logic [N_LANES-1:0]                              lane_tag;
    logic [N_LANES-1:0]                              lane_ctrl;
    logic                                            frame_has_error;
    logic                                            counter_full;

    logic                                            valid_reg;
    logic [NB_FRAME-1:0]                             frame_reg;
    logic [N_LANES-1:0]                              error_mask_reg;
    logic [N_LANES-1:0]                              control_mask_reg;
    logic [NB_COUNTER-1:0]                           error_count;

    // slot k of the bus maps to mask bit k, so the first block ends up in bit N_LANES-1
    genvar lane;
    generate
        for (lane = 0; lane < N_LANES; lane++)
        begin : g_lane
            pcs_pkg::coded_block_t lane_block;

            assign lane_block     = i_data[pcs_pkg::NB_TAGGED*lane +: pcs_pkg::NB_BLOCK];
            assign lane_tag[lane] = i_data[pcs_pkg::NB_TAGGED*lane + pcs_pkg::NB_BLOCK];
            assign lane_ctrl[lane] = (lane_block.ctrl.sync == pcs_pkg::SYNC_CTRL);

            assign stripped_data[pcs_pkg::NB_BLOCK*lane +: pcs_pkg::NB_BLOCK] = lane_block;
        end
    endgenerate

    assign frame_has_error = |lane_tag;
    assign counter_full    = &error_count;  // saturate instead of wrapping

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            valid_reg <= 1'b0;
        end
        else
        begin
            valid_reg <= i_valid;
        end
    end

    // outputs are defined as zero after reset, so the frame registers take it too
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            frame_reg        <= '0;
            error_mask_reg   <= '0;
            control_mask_reg <= '0;
        end
        else if (i_valid)
        begin
            frame_reg        <= stripped_data;
            error_mask_reg   <= lane_tag;
            control_mask_reg <= lane_ctrl;
        end
    end

    // one count per frame with any errored lane, regardless of how many lanes
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            error_count <= '0;
        end
        else if (i_valid && frame_has_error && !counter_full)
        begin
            error_count <= error_count + 1'b1;
        end
    end

    assign o_valid        = valid_reg;
    assign o_data         = frame_reg;
    assign o_error_mask   = error_mask_reg;
    assign o_control_mask = control_mask_reg;
    assign o_error_frames = error_count;

endmodule

// ==== hw/parallel_converter_1_to_n.sv ====
`timescale 1ns/10ps

module parallel_converter_1_to_n
#(
    parameter int N_LANES = 20
)
(
    input  logic                                     i_clock,
    input  logic                                     i_reset,
    input  logic                                     i_valid,
    input  logic [pcs_pkg::NB_TAGGED-1:0]            i_data,

    output logic                                     o_valid,
    output logic [pcs_pkg::NB_TAGGED*N_LANES-1:0]    o_data
);

    localparam int NB_BUS   = pcs_pkg::NB_TAGGED * N_LANES;
    localparam int NB_KEEP  = pcs_pkg::NB_TAGGED * (N_LANES - 1); // every slot but the last
    localparam int NB_INDEX = (N_LANES > 1) ? $clog2(N_LANES) : 1;

    localparam logic [NB_INDEX-1:0] LAST_LANE = NB_INDEX'(N_LANES - 1);

    logic [NB_INDEX-1:0]                             index;
    logic [NB_BUS-1:0]                               collect_data;
    logic [NB_BUS-1:0]                               shadow_data;
    logic                                            frame_valid;
    logic                                            count_done;

    // the N_LANES-th block of a frame is arriving in this cycle
    assign count_done = i_valid && (index == LAST_LANE);

    // lane index counts modulo N_LANES and wraps on the completing block
    always_ff @(posedge i_clock)
    begin
        if (i_reset || count_done)
        begin
            index <= '0;
        end
        else if (i_valid)
        begin
            index <= index + 1'b1;
        end
    end

    // first block lands in the most significant slot, later ones walk downwards
    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            collect_data[NB_BUS-1-(pcs_pkg::NB_TAGGED*index) -: pcs_pkg::NB_TAGGED] <= i_data;
        end
    end

    // the last block goes straight into the shadow so the frame is out one edge later
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            shadow_data <= '0;
        end
        else if (count_done)
        begin
            shadow_data <= {collect_data[NB_BUS-1 -: NB_KEEP], i_data};
        end
    end

    // completion strobe, high for one cycle per frame
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            frame_valid <= 1'b0;
        end
        else
        begin
            frame_valid <= count_done;
        end
    end

    assign o_valid = frame_valid;
    assign o_data  = shadow_data;  // holds until the next frame completes

endmodule

// ==== hw/block_tagger.sv ====
`timescale 1ns/10ps

module block_tagger
(
    input  logic                             i_clock,
    input  logic                             i_reset,
    input  logic                             i_enable,
    input  logic                             i_valid,
    input  pcs_pkg::coded_block_t            i_data,

    output logic                             o_valid,
    output logic [pcs_pkg::NB_TAGGED-1:0]    o_data
);

    logic                                    accept;
    logic                                    sync_is_data;
    logic                                    sync_is_ctrl;
    logic                                    type_is_legal;
    logic                                    bad_header;
    logic                                    bad_type;
    logic                                    block_tag;

    logic                                    valid_reg;
    logic [pcs_pkg::NB_TAGGED-1:0]           tagged_reg;

    // a block only counts while the datapath is enabled
    assign accept = i_enable && i_valid;

    // the sync header is common to both views of the union
    assign sync_is_data = (i_data.data.sync == pcs_pkg::SYNC_DATA);
    assign sync_is_ctrl = (i_data.ctrl.sync == pcs_pkg::SYNC_CTRL);

    assign type_is_legal = pcs_pkg::is_legal_block_type(i_data.ctrl.block_type);

    assign bad_header = !sync_is_data && !sync_is_ctrl;  // 00 and 11 are never valid
    assign bad_type   = sync_is_ctrl && !type_is_legal;  // type only matters for control blocks
    assign block_tag  = bad_header || bad_type;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            valid_reg  <= 1'b0;
            tagged_reg <= '0;
        end
        else
        begin
            valid_reg <= accept;
            if (accept)
            begin
                tagged_reg <= {block_tag, i_data};  // the block and its tag load only on accept
            end
        end
    end

    assign o_valid = valid_reg;
    assign o_data  = tagged_reg;

endmodule

// ==== hw/pcs_pkg.sv ====
package pcs_pkg;

    // widths fixed by the 64b/66b line code
    localparam int NB_SYNC         = 2;
    localparam int NB_BLOCK_TYPE   = 8;
    localparam int NB_BLOCK        = 66;
    localparam int NB_TAGGED       = NB_BLOCK + 1;                 // error tag sits on top
    localparam int NB_DATA_PAYLOAD = NB_BLOCK - NB_SYNC;           // 64 bits after the header
    localparam int NB_CTRL_PAYLOAD = NB_DATA_PAYLOAD - NB_BLOCK_TYPE; // 56 bits after the type

    localparam logic [NB_SYNC-1:0] SYNC_DATA = 2'b01;              // all eight octets are data
    localparam logic [NB_SYNC-1:0] SYNC_CTRL = 2'b10;              // first octet is a block type

    // block type field values that a control block may legally carry
    localparam int N_BLOCK_TYPES = 15;
    localparam logic [NB_BLOCK_TYPE-1:0] LEGAL_BLOCK_TYPES [N_BLOCK_TYPES] = '{
        8'h1E, 8'h2D, 8'h33, 8'h4B, 8'h55,
        8'h66, 8'h78, 8'h87, 8'h99, 8'hAA,
        8'hB4, 8'hCC, 8'hD2, 8'hE1, 8'hFF
    };

    typedef struct packed
    {
        logic [NB_SYNC-1:0]         sync;
        logic [NB_DATA_PAYLOAD-1:0] payload;
    } data_block_t;

    typedef struct packed
    {
        logic [NB_SYNC-1:0]         sync;
        logic [NB_BLOCK_TYPE-1:0]   block_type;
        logic [NB_CTRL_PAYLOAD-1:0] payload;
    } ctrl_block_t;

    // the same 66 bits read either as a data block or as a control block
    typedef union packed
    {
        data_block_t data;
        ctrl_block_t ctrl;
    } coded_block_t;

    // true when the type field matches one entry of the legal list
    function automatic logic is_legal_block_type(input logic [NB_BLOCK_TYPE-1:0] block_type);
        logic legal;
        legal = 1'b0;
        for (int i = 0; i < N_BLOCK_TYPES; i++)
        begin
            if (block_type == LEGAL_BLOCK_TYPES[i])
            begin
                legal = 1'b1;
            end
        end
        return legal;
    endfunction

endpackage
